/* verilog/raster_pkg.sv */
/*
 * Raster bounding-box types
 * Fixed-point coordinate format, vertex, triangle and box structures,
 * and the one-hot multisample rate codes shared by the stage
 */
`default_nettype none

package raster_pkg;

    // Signed fixed point, integer part sits above the RADIX fraction bits
    localparam int COORD_W   = 24;
    localparam int RADIX     = 10;
    localparam int NUM_VERTS = 3;

    typedef logic signed [COORD_W-1:0] coord_t;

    // One axis of a triangle, indexed by vertex number
    typedef coord_t [NUM_VERTS-1:0] axis_vals_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Vertex 0 in the low bits
    typedef vertex_t [NUM_VERTS-1:0] tri_t;

    // Inclusive bounds on one axis
    typedef struct packed {
        coord_t lo;
        coord_t hi;
    } span_t;

    typedef struct packed {
        span_t x;
        span_t y;
    } box_t;

    // Box plus its valid bit, carried together down the pipe
    typedef struct packed {
        box_t box;
        logic valid;
    } box_result_t;

    // Screen extent in the same fixed-point format
    typedef struct packed {
        coord_t width;
        coord_t height;
    } screen_t;

    // One-hot multisample rate
    typedef logic [3:0] ss_rate_t;

    localparam ss_rate_t SS_1X  = 4'b1000;
    localparam ss_rate_t SS_4X  = 4'b0100;
    localparam ss_rate_t SS_16X = 4'b0010;
    localparam ss_rate_t SS_64X = 4'b0001;

endpackage

`default_nettype wire

/* verilog/stall_pipe.sv */
/*
 * Stallable register chain
 * PIPE_DEPTH stages of any payload type, all stages load together
 * while advance is high and hold while it is low
 */
`timescale 1ns/10ps
`default_nettype none

module stall_pipe #(
    parameter int  PIPE_DEPTH = 3,
    parameter type payload_t  = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  payload_t d,
    output payload_t q
);

    // Stage 0 takes the input, last stage drives q
    payload_t stage_q [PIPE_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (advance) begin
            stage_q[0] <= d;
            // Shift everything one stage on
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q = stage_q[PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* verilog/axis_span.sv */
/*
 * Per-axis span unit
 * Min/max of the three vertex coordinates, floor to the multisample
 * grid, clamp to [0, extent] and flag whether the span hits the screen
 */
`timescale 1ns/10ps
`default_nettype none

module axis_span
    import raster_pkg::*;
(
    input  axis_vals_t vals,
    input  coord_t     extent,
    input  ss_rate_t   sub_sample,
    output span_t      span,
    output logic       in_range
);

    // Vertex values as individual signed coordinates
    coord_t               raw [NUM_VERTS];

    // One-hot vertex selects for the low and high bound
    logic [NUM_VERTS-1:0] lo_sel;
    logic [NUM_VERTS-1:0] hi_sel;

    coord_t               lo_raw;
    coord_t               hi_raw;

    // Fraction bits kept for the current rate, 0 to 3
    logic [1:0]           keep_bits;
    logic [RADIX-1:0]     frac_mask;

    coord_t               lo_floor;
    coord_t               hi_floor;

    always_comb begin
        for (int i = 0; i < NUM_VERTS; i++) begin
            raw[i] = vals[i];
        end
    end

    // Vertex i wins if strictly better than lower indices and
    // at least as good as higher ones, so ties go to the lowest index
    always_comb begin
        for (int i = 0; i < NUM_VERTS; i++) begin
            lo_sel[i] = 1'b1;
            hi_sel[i] = 1'b1;
            for (int j = 0; j < NUM_VERTS; j++) begin
                if (j < i) begin
                    lo_sel[i] = lo_sel[i] && (raw[i] < raw[j]);
                    hi_sel[i] = hi_sel[i] && (raw[i] > raw[j]);
                end else if (j > i) begin
                    lo_sel[i] = lo_sel[i] && (raw[i] <= raw[j]);
                    hi_sel[i] = hi_sel[i] && (raw[i] >= raw[j]);
                end
            end
        end
    end

    // AND-OR mux driven by the one-hot selects
    always_comb begin
        lo_raw = '0;
        hi_raw = '0;
        for (int i = 0; i < NUM_VERTS; i++) begin
            lo_raw = lo_raw | (raw[i] & {COORD_W{lo_sel[i]}});
            hi_raw = hi_raw | (raw[i] & {COORD_W{hi_sel[i]}});
        end
    end

    // Rate code to kept fraction bits, unknown codes act as 1x
    always_comb begin
        case (sub_sample)
            SS_1X:   keep_bits = 2'd0;
            SS_4X:   keep_bits = 2'd1;
            SS_16X:  keep_bits = 2'd2;
            SS_64X:  keep_bits = 2'd3;
            default: keep_bits = 2'd0;
        endcase
    end

    // Keep the top keep_bits of the fraction, clear the rest
    assign frac_mask = ~({RADIX{1'b1}} >> keep_bits);

    // Integer part passes through, so negatives floor toward minus infinity
    assign lo_floor = lo_raw & {{(COORD_W-RADIX){1'b1}}, frac_mask};
    assign hi_floor = hi_raw & {{(COORD_W-RADIX){1'b1}}, frac_mask};

    always_comb begin
        // Low bound stops at the screen origin
        span.lo = lo_floor[COORD_W-1] ? '0 : lo_floor;
        // High bound stops at the screen edge
        span.hi = (hi_floor >= extent) ? extent : hi_floor;
        // Off-screen when wholly below zero or wholly past the edge
        in_range = !hi_floor[COORD_W-1] && (lo_floor < extent);
    end

    // Checks only once the inputs carry real values
    always_comb begin
        if (!$isunknown({vals, extent, sub_sample})) begin
            a_sel_onehot: assert ($onehot(lo_sel) && $onehot(hi_sel))
                else $error("axis_span min/max select not one-hot");
            a_floor_down: assert ((lo_floor <= lo_raw) && (hi_floor <= hi_raw))
                else $error("axis_span floored bound above raw bound");
            a_hi_on_screen: assert (!in_range || ((span.lo <= span.hi) && (span.hi <= extent)))
                else $error("axis_span on-screen span inverted or past extent");
        end
    end

endmodule

`default_nettype wire

/* verilog/bbox_merge.sv */
/*
 * Bounding box merge
 * Joins the x and y spans into one box, qualifies it with the
 * triangle valid and both on-screen flags, then pipelines the result
 */
`timescale 1ns/10ps
`default_nettype none

module bbox_merge
    import raster_pkg::*;
#(
    parameter int PIPE_DEPTH = 3
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  advance,
    input  span_t x_span,
    input  span_t y_span,
    input  logic  x_in_range,
    input  logic  y_in_range,
    input  logic  tri_valid,
    output box_t  box,
    output logic  box_valid
);

    // Result before and after the register chain
    box_result_t result_d;
    box_result_t result_q;

    always_comb begin
        result_d.box.x = x_span;
        result_d.box.y = y_span;
        // Rejected when either axis misses the screen
        result_d.valid = tri_valid && x_in_range && y_in_range;
    end

    stall_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH),
        .payload_t  (box_result_t)
    ) result_pipe_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .d       (result_d),
        .q       (result_q)
    );

    assign box       = result_q.box;
    assign box_valid = result_q.valid;

    // Valid boxes leaving the stage are never inverted on either axis
    property box_ordered;
        @(posedge clk) disable iff (!rst_n)
            box_valid |-> (($signed(box.x.lo) <= $signed(box.x.hi))
                        && ($signed(box.y.lo) <= $signed(box.y.hi)));
    endproperty

    a_box_ordered: assert property (box_ordered)
        else $error("bbox_merge low corner above high corner");

endmodule

`default_nettype wire

/* verilog/bbox_top.sv */
/*
 * Bounding box stage top
 * x and y span units side by side, the merge pipe for the box
 * and a matching pipe that carries the triangle alongside it
 */
`timescale 1ns/10ps
`default_nettype none

module bbox_top
    import raster_pkg::*;
#(
    parameter int PIPE_DEPTH = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  tri_t     in_tri,
    input  logic     tri_valid,
    input  logic     advance,
    input  screen_t  screen,
    input  ss_rate_t sub_sample,
    output tri_t     out_tri,
    output box_t     box,
    output logic     box_valid
);

    axis_vals_t x_vals;
    axis_vals_t y_vals;
    span_t      x_span;
    span_t      y_span;
    logic       x_in_range;
    logic       y_in_range;

    // Split the triangle into its two axes
    always_comb begin
        for (int i = 0; i < NUM_VERTS; i++) begin
            x_vals[i] = in_tri[i].x;
            y_vals[i] = in_tri[i].y;
        end
    end

    axis_span x_span_i (
        .vals       (x_vals),
        .extent     (screen.width),
        .sub_sample (sub_sample),
        .span       (x_span),
        .in_range   (x_in_range)
    );

    axis_span y_span_i (
        .vals       (y_vals),
        .extent     (screen.height),
        .sub_sample (sub_sample),
        .span       (y_span),
        .in_range   (y_in_range)
    );

    bbox_merge #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) bbox_merge_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .x_span     (x_span),
        .y_span     (y_span),
        .x_in_range (x_in_range),
        .y_in_range (y_in_range),
        .tri_valid  (tri_valid),
        .box        (box),
        .box_valid  (box_valid)
    );

    // Same depth as the box path so triangle and box leave together
    stall_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH),
        .payload_t  (tri_t)
    ) tri_pipe_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .d       (in_tri),
        .q       (out_tri)
    );

endmodule

`default_nettype wire

/* verification/tb_bbox_top.sv */
/*
 * Testbench for the bounding-box stage
 * Directed tests for reset, multisample flooring, clamping and rejection,
 * then a random stream with stalls checked against a reference model
 */
`timescale 1ns/10ps
`default_nettype none

module tb_bbox_top
    import raster_pkg::*;
();

    localparam int          PIPE_DEPTH = 3;
    localparam int          WAIT_LIMIT = 50;
    localparam int          STREAM_LEN = 200;
    localparam logic [31:0] SEED       = 32'he62d75eb;

    logic     clk;
    logic     rst_n;
    tri_t     in_tri;
    logic     tri_valid;
    logic     advance;
    screen_t  screen;
    ss_rate_t sub_sample;
    tri_t     out_tri;
    box_t     box;
    logic     box_valid;

    int       error_count;
    int       check_count;
    int       timeout_count;

    bbox_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) bbox_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_tri     (in_tri),
        .tri_valid  (tri_valid),
        .advance    (advance),
        .screen     (screen),
        .sub_sample (sub_sample),
        .out_tri    (out_tri),
        .box        (box),
        .box_valid  (box_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Coordinates in eighths of a pixel, fine enough for every rate
    function automatic coord_t from_eighths(input int n);
        return coord_t'(n * (1 << (RADIX - 3)));
    endfunction

    function automatic tri_t make_tri(input coord_t x0, y0, x1, y1, x2, y2);
        tri_t t;
        t[0].x = x0;
        t[0].y = y0;
        t[1].x = x1;
        t[1].y = y1;
        t[2].x = x2;
        t[2].y = y2;
        return t;
    endfunction

    function automatic box_t make_box(input coord_t xlo, xhi, ylo, yhi);
        box_t b;
        b.x.lo = xlo;
        b.x.hi = xhi;
        b.y.lo = ylo;
        b.y.hi = yhi;
        return b;
    endfunction

    // Whole part from -100 up, random fraction below it
    function automatic coord_t random_coord(input int range);
        int whole;
        int frac;
        whole = int'($urandom_range(0, range)) - 100;
        frac  = int'($urandom_range(0, (1 << RADIX) - 1));
        return coord_t'(whole * (1 << RADIX) + frac);
    endfunction

    // Clear fraction bits below the kept count, other codes act as 1x
    function automatic coord_t floor_to_rate(input coord_t v, input ss_rate_t rate);
        int     kept;
        coord_t below;
        case (rate)
            SS_4X:   kept = 1;
            SS_16X:  kept = 2;
            SS_64X:  kept = 3;
            default: kept = 0;
        endcase
        below = coord_t'((1 << (RADIX - kept)) - 1);
        return v & ~below;
    endfunction

    // Reference for one axis: min/max, floor, clamp, on-screen test
    task automatic expect_axis(input coord_t a, b, c, input coord_t extent,
                               input ss_rate_t rate, output span_t span, output logic hit);
        coord_t lo;
        coord_t hi;
        lo = a;
        hi = a;
        if (b < lo) lo = b;
        if (c < lo) lo = c;
        if (b > hi) hi = b;
        if (c > hi) hi = c;
        lo = floor_to_rate(lo, rate);
        hi = floor_to_rate(hi, rate);
        // Missed when the span ends left of zero or starts at or past the edge
        hit     = !((hi < 0) || (lo >= extent));
        span.lo = (lo < 0) ? coord_t'(0) : lo;
        span.hi = (hi < extent) ? hi : extent;
    endtask

    task automatic expect_result(input tri_t t, input logic v, input screen_t scr,
                                 input ss_rate_t rate, output box_result_t r);
        logic x_hit;
        logic y_hit;
        expect_axis(t[0].x, t[1].x, t[2].x, scr.width, rate, r.box.x, x_hit);
        expect_axis(t[0].y, t[1].y, t[2].y, scr.height, rate, r.box.y, y_hit);
        r.valid = v && x_hit && y_hit;
    endtask

    task automatic check_box(input box_t got, input box_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s, box %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tri(input tri_t got, input tri_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s, triangle %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s, valid %b expected %b", $time, what, got, exp);
        end
    endtask

    // Count rising edges that saw advance high
    task automatic wait_enabled_edges(input int n);
        int seen;
        int edges;
        seen  = 0;
        edges = 0;
        while (seen < n && edges < WAIT_LIMIT) begin
            @(posedge clk);
            edges++;
            if (advance) seen++;
        end
        if (seen < n) begin
            timeout_count++;
            $display("Timed out waiting for %0d enabled clock edges", n);
        end
    endtask

    // One triangle in, idle behind it, result checked at the far end
    task automatic run_directed(input string name, input tri_t t, input logic v,
                                input ss_rate_t rate, input box_t exp_box,
                                input logic exp_valid);
        @(posedge clk);
        in_tri     <= t;
        tri_valid  <= v;
        sub_sample <= rate;
        advance    <= 1'b1;
        wait_enabled_edges(1);
        in_tri    <= '0;
        tri_valid <= 1'b0;
        wait_enabled_edges(PIPE_DEPTH - 1);
        @(negedge clk);
        check_valid(box_valid, exp_valid, {name, " valid"});
        if (exp_valid) check_box(box, exp_box, {name, " box"});
        check_tri(out_tri, t, {name, " triangle"});
    endtask

    // v0 (10.75, 20.5)  v1 (30.25, 5.875)  v2 (15.0, 40.125)
    function automatic tri_t frac_tri();
        return make_tri(from_eighths(86), from_eighths(164), from_eighths(242),
                        from_eighths(47), from_eighths(120), from_eighths(321));
    endfunction

    task automatic test_reset();
        @(negedge clk);
        check_valid(box_valid, 1'b0, "reset valid");
        check_box(box, '0, "reset box");
        check_tri(out_tri, '0, "reset triangle");
    endtask

    task automatic test_rates();
        run_directed("1x", frac_tri(), 1'b1, SS_1X,
                     make_box(from_eighths(80), from_eighths(240),
                              from_eighths(40), from_eighths(320)), 1'b1);
        // Half pixel grid
        run_directed("4x", frac_tri(), 1'b1, SS_4X,
                     make_box(from_eighths(84), from_eighths(240),
                              from_eighths(44), from_eighths(320)), 1'b1);
        run_directed("16x", frac_tri(), 1'b1, SS_16X,
                     make_box(from_eighths(86), from_eighths(242),
                              from_eighths(46), from_eighths(320)), 1'b1);
        // Eighth grid keeps every corner as is
        run_directed("64x", frac_tri(), 1'b1, SS_64X,
                     make_box(from_eighths(86), from_eighths(242),
                              from_eighths(47), from_eighths(321)), 1'b1);
    endtask

    task automatic test_clamp();
        run_directed("clamp", make_tri(from_eighths(-44), from_eighths(-16),
                                       from_eighths(5602), from_eighths(4006),
                                       from_eighths(800), from_eighths(400)),
                     1'b1, SS_1X, make_box('0, screen.width, '0, screen.height), 1'b1);
    endtask

    task automatic test_reject();
        run_directed("left", make_tri(from_eighths(-400), from_eighths(80),
                                      from_eighths(-164), from_eighths(400),
                                      from_eighths(-26), from_eighths(200)),
                     1'b1, SS_1X, '0, 1'b0);
        run_directed("above", make_tri(from_eighths(80), from_eighths(-8),
                                       from_eighths(400), from_eighths(-400),
                                       from_eighths(200), from_eighths(-100)),
                     1'b1, SS_4X, '0, 1'b0);
        // Starts exactly on the right edge
        run_directed("right", make_tri(from_eighths(5120), from_eighths(80),
                                       from_eighths(6000), from_eighths(400),
                                       from_eighths(5500), from_eighths(200)),
                     1'b1, SS_16X, '0, 1'b0);
        run_directed("not valid", frac_tri(), 1'b0, SS_1X, '0, 1'b0);
    endtask

    task automatic drive_random();
        tri_t     t;
        ss_rate_t rate;
        for (int i = 0; i < NUM_VERTS; i++) begin
            t[i].x = random_coord(900);
            t[i].y = random_coord(700);
        end
        case ($urandom_range(0, 4))
            0:       rate = SS_1X;
            1:       rate = SS_4X;
            2:       rate = SS_16X;
            3:       rate = SS_64X;
            default: rate = 4'b0110;
        endcase
        in_tri     <= t;
        sub_sample <= rate;
        tri_valid  <= ($urandom_range(0, 7) != 0);
        advance    <= ($urandom_range(0, 2) != 0);
    endtask

    // Back to back random triangles, advance dropped about a third of the time
    // The model only moves on enabled edges, so a stalled cycle expects
    // the same outputs as the cycle before it
    task automatic test_stream(input int count);
        box_result_t model_res [PIPE_DEPTH];
        tri_t        model_tri [PIPE_DEPTH];
        int          issued;
        int          cycles;
        // Flush with idle triangles so the model starts from known stages
        @(posedge clk);
        in_tri    <= '0;
        tri_valid <= 1'b0;
        advance   <= 1'b1;
        wait_enabled_edges(PIPE_DEPTH);
        for (int i = 0; i < PIPE_DEPTH; i++) begin
            expect_result('0, 1'b0, screen, sub_sample, model_res[i]);
            model_tri[i] = '0;
        end
        issued = 0;
        cycles = 0;
        drive_random();
        while (issued < count && cycles < count * 4) begin
            @(posedge clk);
            cycles++;
            // Inputs seen here are the ones the DUT samples on this edge
            if (advance) begin
                for (int i = PIPE_DEPTH - 1; i > 0; i--) begin
                    model_res[i] = model_res[i-1];
                    model_tri[i] = model_tri[i-1];
                end
                expect_result(in_tri, tri_valid, screen, sub_sample, model_res[0]);
                model_tri[0] = in_tri;
                issued++;
            end
            drive_random();
            @(negedge clk);
            check_box(box, model_res[PIPE_DEPTH-1].box, "stream box");
            check_valid(box_valid, model_res[PIPE_DEPTH-1].valid, "stream valid");
            check_tri(out_tri, model_tri[PIPE_DEPTH-1], "stream triangle");
        end
        if (issued < count) begin
            timeout_count++;
            $display("Timed out in the stream after %0d of %0d triangles", issued, count);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        error_count   = 0;
        check_count   = 0;
        timeout_count = 0;
        rst_n         = 1'b0;
        in_tri        = '0;
        tri_valid     = 1'b0;
        advance       = 1'b0;
        sub_sample    = SS_1X;
        // 640 x 480 pixels
        screen.width  = from_eighths(640 * 8);
        screen.height = from_eighths(480 * 8);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_rates();
        test_clamp();
        test_reject();
        test_stream(STREAM_LEN);

        $display("checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
verilog/raster_pkg.sv
verilog/stall_pipe.sv
verilog/axis_span.sv
verilog/bbox_merge.sv
verilog/bbox_top.sv
verification/tb_bbox_top.sv

/* run.sh */
#!/bin/sh
# Build and run the bounding-box stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_bbox_top \
    -o tb_bbox_top

# The simulation may stop on an assertion, so the search decides the result
out=$(./obj_dir/tb_bbox_top) || true
echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
    exit 0
else
    exit 1
fi
